/* hw/ddr_test_defines.svh */
`ifndef DDR_TEST_DEFINES_SVH
`define DDR_TEST_DEFINES_SVH

`define DDR_DATA_W 32      // one user-port data beat
`define DDR_ADDR_W 30      // user-port address
`define REG_ADDR_W 4       // host register address

`define REG_CTRL      4'd0 // bit 0 active, bit 1 clear_fail
`define REG_INCR      4'd1
`define REG_STOP      4'd2
`define REG_STATUS    4'd3
`define REG_ERR_ADDR  4'd4
`define REG_RD_BUSY   4'd5
`define REG_RD_IDLE   4'd6
`define REG_WR_BUSY   4'd7
`define REG_WR_IDLE   4'd8
`define REG_MAX_STALL 4'd9 // rd in [15:0], wr in [31:16]

`endif

/* hw/ddr_test_pkg.sv */
`include "ddr_test_defines.svh"

package ddr_test_pkg;

   typedef enum logic [2:0] {
      APP_CMD_WRITE = 3'b000,
      APP_CMD_READ  = 3'b001
   } app_cmd_e;

   typedef struct packed {
      logic                   en;
      app_cmd_e               cmd;
      logic [`DDR_ADDR_W-1:0] addr;
   } app_req_t;

   typedef struct packed {
      logic                   wren;
      logic                   last;       // second beat of a burst
      logic [`DDR_DATA_W-1:0] data;
   } app_wdata_t;

   typedef struct packed {
      logic                   rdy;        // command accept
      logic                   wdf_rdy;    // write data accept
      logic                   rd_valid;
      logic                   rd_end;     // last beat of a read burst
      logic [`DDR_DATA_W-1:0] rd_data;
   } app_rsp_t;

   typedef struct packed {
      logic                   active;
      logic                   clear_fail; // single-cycle pulse
      logic [7:0]             incr;
      logic [`DDR_ADDR_W-1:0] stop;
   } test_cfg_t;

   typedef struct packed {
      logic                   pass;
      logic                   fail;
      logic [15:0]            iteration;
      logic [7:0]             errors;     // saturates at 255
      logic [`DDR_ADDR_W-1:0] error_addr;
   } test_status_t;

   typedef struct packed {
      logic [31:0]            busy;
      logic [31:0]            idle;
      logic [15:0]            max_stall;
   } dir_stats_t;

endpackage

/* hw/ddr_test_regs.sv */
`timescale 1ns/1ps
`include "ddr_test_defines.svh"

module ddr_test_regs (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       req,
   input  logic                       we,
   input  logic [`REG_ADDR_W-1:0]     addr,
   input  logic [31:0]                wdata,
   output logic                       ack,
   output logic [31:0]                rdata,
   output ddr_test_pkg::test_cfg_t    cfg,
   input  ddr_test_pkg::test_status_t status,
   input  ddr_test_pkg::dir_stats_t   rd_stats,
   input  ddr_test_pkg::dir_stats_t   wr_stats
);

   logic        access;   // req seen, ack not yet raised
   logic [31:0] read_mux;

   assign access = req && !ack;

   always_ff @(posedge clk) begin
      if (reset) begin
         ack            <= 1'b0;
         cfg.active     <= 1'b0;
         cfg.clear_fail <= 1'b0;
         cfg.incr       <= 8'd1;
         cfg.stop       <= '0;
      end else begin
         ack            <= req;   // rises and falls one cycle behind req
         cfg.clear_fail <= access && we && (addr == `REG_CTRL) && wdata[1];
         if (access && we) begin
            case (addr)
               `REG_CTRL: cfg.active <= wdata[0];
               `REG_INCR: cfg.incr   <= wdata[7:0];
               `REG_STOP: cfg.stop   <= wdata[`DDR_ADDR_W-1:0];
               default: ;             // remaining offsets are read only
            endcase
         end
      end
   end

   always_comb begin
      case (addr)
         `REG_CTRL:      read_mux = {31'd0, cfg.active};
         `REG_INCR:      read_mux = {24'd0, cfg.incr};
         `REG_STOP:      read_mux = {{(32-`DDR_ADDR_W){1'b0}}, cfg.stop};
         `REG_STATUS:    read_mux = {status.iteration, status.errors, 6'd0,
                                     status.fail, status.pass};
         `REG_ERR_ADDR:  read_mux = {{(32-`DDR_ADDR_W){1'b0}}, status.error_addr};
         `REG_RD_BUSY:   read_mux = rd_stats.busy;
         `REG_RD_IDLE:   read_mux = rd_stats.idle;
         `REG_WR_BUSY:   read_mux = wr_stats.busy;
         `REG_WR_IDLE:   read_mux = wr_stats.idle;
         `REG_MAX_STALL: read_mux = {wr_stats.max_stall, rd_stats.max_stall};
         default:        read_mux = 32'd0;
      endcase
   end

   // captured with the rising ack, stays put until the next access
   always_ff @(posedge clk) begin
      if (access) begin
         rdata <= read_mux;
      end
   end

endmodule

/* hw/pattern_lfsr.sv */
`timescale 1ns/1ps

module pattern_lfsr (
   input  logic        clk,
   input  logic        reset,
   input  logic        seed,
   input  logic        advance,
   input  logic [15:0] iteration,
   output logic [31:0] value
);

   logic feedback;

   // taps 31, 21, 1, 0
   assign feedback = value[31] ^ value[21] ^ value[1] ^ value[0];

   always_ff @(posedge clk) begin
      if (reset) begin
         value <= 32'd0;
      end else if (seed) begin
         value <= {iteration, ~iteration};   // never all zero
      end else if (advance) begin
         value <= {value[30:0], feedback};   // one step per data beat
      end
   end

endmodule

/* hw/ddr_rw_sequencer.sv */
`timescale 1ns/1ps
`include "ddr_test_defines.svh"

module ddr_rw_sequencer (
   input  logic                     clk,
   input  logic                     reset,
   input  ddr_test_pkg::test_cfg_t  cfg,
   input  logic                     calib_done,
   input  ddr_test_pkg::app_rsp_t   rsp,
   input  logic [31:0]              pattern,
   input  logic                     verify_done,
   output ddr_test_pkg::app_req_t   req,
   output ddr_test_pkg::app_wdata_t wdata,
   output logic                     seed,
   output logic                     advance,
   output logic [15:0]              iteration,
   output logic                     pass,
   input  logic                     fail,
   output logic                     reading,
   output logic                     writing,
   output logic                     restart
);

   import ddr_test_pkg::*;

   localparam int ADDR_W = `DDR_ADDR_W;

   typedef enum logic [2:0] {
      S_IDLE,
      S_WRITE_CMD,    // command plus first beat
      S_WRITE_LAST,   // second beat
      S_READ_START,
      S_READ_CMD,
      S_WAIT_READS,
      S_RELOAD
   } state_e;

   state_e            state;
   state_e            next_state;
   logic [ADDR_W-1:0] cmd_addr;
   logic              active_q;
   logic              cmd_sent;      // command half of S_WRITE_CMD already taken
   logic              beat_sent;     // data half of S_WRITE_CMD already taken
   logic              cmd_ok;
   logic              beat_ok;
   logic              at_stop;
   logic              clear_addr;
   logic              step_addr;
   logic              next_iteration;

   assign at_stop = (cmd_addr == cfg.stop);
   assign restart = cfg.active && !active_q;
   assign writing = (state == S_WRITE_CMD) || (state == S_WRITE_LAST);
   assign reading = (state == S_READ_START) || (state == S_READ_CMD) ||
                    (state == S_WAIT_READS);
   assign cmd_ok  = cmd_sent || rsp.rdy;
   assign beat_ok = beat_sent || rsp.wdf_rdy;

   always_comb begin
      next_state     = state;
      req.en         = 1'b0;
      req.cmd        = writing ? APP_CMD_WRITE : APP_CMD_READ;
      req.addr       = cmd_addr;
      wdata.wren     = 1'b0;
      wdata.last     = 1'b0;
      wdata.data     = pattern ^ 32'(cmd_addr);
      seed           = 1'b0;
      advance        = 1'b0;
      clear_addr     = 1'b0;
      step_addr      = 1'b0;
      next_iteration = 1'b0;
      case (state)
         S_IDLE: begin
            if (cfg.active && calib_done && rsp.rdy && rsp.wdf_rdy) begin
               seed       = 1'b1;
               clear_addr = 1'b1;
               next_state = S_WRITE_CMD;
            end
         end
         S_WRITE_CMD: begin
            req.en     = !cmd_sent;
            wdata.wren = !beat_sent;
            advance    = !beat_sent && rsp.wdf_rdy;
            if (cmd_ok && beat_ok) begin
               next_state = S_WRITE_LAST;
            end
         end
         S_WRITE_LAST: begin
            wdata.wren = 1'b1;
            wdata.last = 1'b1;
            if (rsp.wdf_rdy) begin
               advance = 1'b1;
               if (!cfg.active) begin
                  next_state = S_IDLE;
               end else if (at_stop) begin
                  clear_addr = 1'b1;
                  next_state = S_READ_START;
               end else begin
                  step_addr  = 1'b1;
                  next_state = S_WRITE_CMD;
               end
            end
         end
         S_READ_START: begin
            seed       = 1'b1;      // replay the pattern of this iteration
            next_state = cfg.active ? S_READ_CMD : S_IDLE;
         end
         S_READ_CMD: begin
            req.en = 1'b1;
            if (rsp.rdy) begin
               if (!cfg.active) begin
                  next_state = S_IDLE;
               end else if (at_stop) begin
                  next_state = S_WAIT_READS;
               end else begin
                  step_addr = 1'b1;
               end
            end
         end
         S_WAIT_READS: begin
            if (!cfg.active) begin
               next_state = S_IDLE;
            end else if (verify_done) begin
               clear_addr     = 1'b1;
               next_iteration = 1'b1;
               next_state     = S_RELOAD;
            end
         end
         S_RELOAD: begin
            seed       = 1'b1;      // iteration already stepped here
            next_state = cfg.active ? S_WRITE_CMD : S_IDLE;
         end
         default: next_state = S_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= S_IDLE;
         cmd_addr  <= '0;
         iteration <= 16'd0;
         pass      <= 1'b0;
         active_q  <= 1'b0;
         cmd_sent  <= 1'b0;
         beat_sent <= 1'b0;
      end else begin
         state    <= next_state;
         active_q <= cfg.active;
         if (clear_addr) begin
            cmd_addr <= '0;
         end else if (step_addr) begin
            cmd_addr <= cmd_addr + ADDR_W'(cfg.incr);
         end
         if (state == S_IDLE) begin
            iteration <= 16'd0;
         end else if (next_iteration) begin
            iteration <= iteration + 16'd1;
         end
         if (!cfg.active || cfg.clear_fail || fail) begin
            pass <= 1'b0;
         end else if (next_iteration) begin
            pass <= 1'b1;
         end
         if ((state == S_WRITE_CMD) && (next_state == S_WRITE_CMD)) begin
            cmd_sent  <= cmd_ok;
            beat_sent <= beat_ok;
         end else begin
            cmd_sent  <= 1'b0;
            beat_sent <= 1'b0;
         end
      end
   end

endmodule

/* hw/read_checker.sv */
`timescale 1ns/1ps
`include "ddr_test_defines.svh"

module read_checker (
   input  logic                    clk,
   input  logic                    reset,
   input  ddr_test_pkg::test_cfg_t cfg,
   input  ddr_test_pkg::app_rsp_t  rsp,
   input  logic                    reading,
   input  logic [31:0]             pattern,
   input  logic                    restart,
   output logic                    advance,
   output logic                    verify_done,
   output logic                    fail,
   output logic [7:0]              errors,
   output logic [`DDR_ADDR_W-1:0]  error_addr
);

   localparam int ADDR_W = `DDR_ADDR_W;

   logic [ADDR_W-1:0] verify_addr;   // address of the burst now returning
   logic [31:0]       expected;
   logic              beat_valid;
   logic              last_burst;

   assign expected   = pattern ^ 32'(verify_addr);
   assign beat_valid = reading && rsp.rd_valid;
   assign last_burst = reading && (verify_addr == cfg.stop);
   assign advance    = beat_valid;

   always_ff @(posedge clk) begin
      if (reset) begin
         verify_addr <= '0;
         verify_done <= 1'b0;
         fail        <= 1'b0;
         errors      <= 8'd0;
         error_addr  <= '0;
      end else begin
         // one cycle late so fail already covers the final beat
         verify_done <= beat_valid && rsp.rd_end && last_burst;
         if (restart) begin
            verify_addr <= '0;
         end else if (rsp.rd_valid && rsp.rd_end) begin
            verify_addr <= last_burst ? '0 : verify_addr + ADDR_W'(cfg.incr);
         end
         if (cfg.clear_fail) begin
            fail       <= 1'b0;
            errors     <= 8'd0;
            error_addr <= '0;
         end else if (beat_valid && (rsp.rd_data != expected)) begin
            fail <= 1'b1;
            if (errors == 8'd0) begin
               error_addr <= verify_addr;   // first failure only
            end
            if (errors != 8'hff) begin
               errors <= errors + 8'd1;
            end
         end
      end
   end

endmodule

/* hw/ddr_traffic_stats.sv */
`timescale 1ns/1ps

module ddr_traffic_stats (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     restart,
   input  logic                     phase,
   input  logic                     beat,
   output ddr_test_pkg::dir_stats_t stats
);

   logic [15:0] stall_run;    // idle cycles since the last beat
   logic [15:0] stall_next;

   assign stall_next = (stall_run == 16'hffff) ? stall_run : stall_run + 16'd1;

   always_ff @(posedge clk) begin
      if (reset || restart) begin
         stats.busy      <= 32'd0;
         stats.idle      <= 32'd0;
         stats.max_stall <= 16'd0;
         stall_run       <= 16'd0;
      end else if (phase) begin
         if (beat) begin
            if (stats.busy != 32'hffff_ffff) begin
               stats.busy <= stats.busy + 32'd1;
            end
            stall_run <= 16'd0;
         end else begin
            if (stats.idle != 32'hffff_ffff) begin
               stats.idle <= stats.idle + 32'd1;
            end
            stall_run <= stall_next;
            if (stall_next > stats.max_stall) begin
               stats.max_stall <= stall_next;
            end
         end
      end else begin
         stall_run <= 16'd0;    // a stall never spans two phases
      end
   end

endmodule

/* hw/ddr_test_top.sv */
`timescale 1ns/1ps
`include "ddr_test_defines.svh"

module ddr_test_top (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     req,
   input  logic                     we,
   input  logic [`REG_ADDR_W-1:0]   addr,
   input  logic [31:0]              wdata,
   output logic                     ack,
   output logic [31:0]              rdata,
   input  logic                     calib_done,
   output ddr_test_pkg::app_req_t   app_req,
   output ddr_test_pkg::app_wdata_t app_wdata,
   input  ddr_test_pkg::app_rsp_t   app_rsp
);

   import ddr_test_pkg::*;

   test_cfg_t              cfg;
   test_status_t           status;
   dir_stats_t             rd_stats;
   dir_stats_t             wr_stats;
   logic [31:0]            pattern;
   logic [15:0]            iteration;
   logic [7:0]             errors;
   logic [`DDR_ADDR_W-1:0] error_addr;
   logic                   seed;
   logic                   seq_advance;
   logic                   chk_advance;
   logic                   verify_done;
   logic                   pass;
   logic                   fail;
   logic                   reading;
   logic                   writing;
   logic                   restart;
   logic                   wr_beat;

   assign status = '{pass: pass, fail: fail, iteration: iteration,
                     errors: errors, error_addr: error_addr};
   assign wr_beat = app_wdata.wren && app_rsp.wdf_rdy;   // accepted write beat

   ddr_test_regs i_regs (
      .clk(clk), .reset(reset), .req(req), .we(we), .addr(addr), .wdata(wdata),
      .ack(ack), .rdata(rdata), .cfg(cfg), .status(status),
      .rd_stats(rd_stats), .wr_stats(wr_stats)
   );

   ddr_rw_sequencer i_sequencer (
      .clk(clk), .reset(reset), .cfg(cfg), .calib_done(calib_done), .rsp(app_rsp),
      .pattern(pattern), .verify_done(verify_done), .req(app_req), .wdata(app_wdata),
      .seed(seed), .advance(seq_advance), .iteration(iteration), .pass(pass),
      .fail(fail), .reading(reading), .writing(writing), .restart(restart)
   );

   read_checker i_checker (
      .clk(clk), .reset(reset), .cfg(cfg), .rsp(app_rsp), .reading(reading),
      .pattern(pattern), .restart(restart), .advance(chk_advance),
      .verify_done(verify_done), .fail(fail), .errors(errors), .error_addr(error_addr)
   );

   // write and read phases never overlap
   pattern_lfsr i_lfsr (
      .clk(clk), .reset(reset), .seed(seed), .advance(seq_advance | chk_advance),
      .iteration(iteration), .value(pattern)
   );

   ddr_traffic_stats i_rd_stats (
      .clk(clk), .reset(reset), .restart(restart), .phase(reading),
      .beat(app_rsp.rd_valid), .stats(rd_stats)
   );

   ddr_traffic_stats i_wr_stats (
      .clk(clk), .reset(reset), .restart(restart), .phase(writing),
      .beat(wr_beat), .stats(wr_stats)
   );

endmodule

/* dv/app_mem_model.sv */
`timescale 1ns/1ps
`include "ddr_test_defines.svh"

module app_mem_model (
   input  logic                     clk,
   input  logic                     reset,
   input  ddr_test_pkg::app_req_t   req,
   input  ddr_test_pkg::app_wdata_t wdata,
   input  logic                     inject_en,
   input  logic [`DDR_ADDR_W-1:0]   inject_addr,
   input  logic                     clear_counts,
   output ddr_test_pkg::app_rsp_t   rsp,
   output int                       wr_beats,
   output int                       rd_beats,
   output int                       bad_beats,
   output int                       max_wr_stall,
   output int                       max_rd_gap,
   output int                       reads_pending
);

   import ddr_test_pkg::*;

   logic [31:0]            mem [longint];   // two beats per address, key = 2*addr + beat
   logic [`DDR_ADDR_W-1:0] waddr_q[$];
   logic [31:0]            wbeat_q[$];
   logic [`DDR_ADDR_W-1:0] raddr_q[$];
   longint                 rdue_q[$];
   logic [`DDR_ADDR_W-1:0] cur_addr;
   logic                   second;          // beat 1 of a burst goes out next
   logic                   gap_open;        // a read beat was seen in this pass
   integer                 seed = 32'h75a3;
   longint                 cyc;
   longint                 next_free;
   longint                 due;
   int                     wr_run;
   int                     gap;

   function automatic logic [31:0] stored(input longint key);
      if (mem.exists(key)) begin
         return mem[key];
      end
      return 32'(key) ^ 32'(key >> 32) ^ 32'hc3a5_96e1;   // fill for unwritten words
   endfunction

   task automatic send_beat(input logic [`DDR_ADDR_W-1:0] a, input logic last);
      logic [31:0] d;
      d = stored(2 * longint'(a) + longint'(last));
      if (inject_en && (a == inject_addr)) begin
         d = d ^ 32'h0000_0010;                 // single flipped bit
         bad_beats = bad_beats + 1;
      end
      rsp.rd_valid <= 1'b1;
      rsp.rd_end   <= last;
      rsp.rd_data  <= d;
      rd_beats = rd_beats + 1;
   endtask

   always @(posedge clk) begin
      if (reset) begin
         rsp <= '0;
         waddr_q.delete();
         wbeat_q.delete();
         raddr_q.delete();
         rdue_q.delete();
         second = 1'b0;
         gap_open = 1'b0;
         cyc = 0;
         next_free = 0;
         wr_run = 0;
         gap = 0;
         wr_beats = 0;
         rd_beats = 0;
         bad_beats = 0;
         max_wr_stall = 0;
         max_rd_gap = 0;
      end else begin
         cyc = cyc + 1;
         if (clear_counts) begin
            wr_beats = 0;
            rd_beats = 0;
            bad_beats = 0;
            max_wr_stall = 0;
            max_rd_gap = 0;
            gap_open = 1'b0;
         end
         rsp.rdy      <= ($random(seed) & 3) != 0;   // stalls about a quarter of cycles
         rsp.wdf_rdy  <= ($random(seed) & 3) != 0;
         rsp.rd_valid <= 1'b0;
         rsp.rd_end   <= 1'b0;
         if (req.en && rsp.rdy) begin
            if (req.cmd == APP_CMD_WRITE) begin
               waddr_q.push_back(req.addr);
            end else begin
               due = cyc + 1 + longint'($unsigned($random(seed)) % 8);
               if (due < next_free) begin
                  due = next_free;                   // keep returns in order
               end
               raddr_q.push_back(req.addr);
               rdue_q.push_back(due);
               next_free = due + 2;
            end
         end
         if (wdata.wren && rsp.wdf_rdy) begin
            wbeat_q.push_back(wdata.data);
            wr_beats = wr_beats + 1;
            wr_run = 0;
            gap_open = 1'b0;
         end else if (wdata.wren) begin
            wr_run = wr_run + 1;
            if (wr_run > max_wr_stall) begin
               max_wr_stall = wr_run;
            end
         end else begin
            wr_run = 0;
         end
         if ((waddr_q.size() > 0) && (wbeat_q.size() >= 2)) begin
            mem[2 * longint'(waddr_q[0])]     = wbeat_q.pop_front();
            mem[2 * longint'(waddr_q[0]) + 1] = wbeat_q.pop_front();
            void'(waddr_q.pop_front());
         end
         if (second) begin
            send_beat(cur_addr, 1'b1);
            second = 1'b0;
         end else if ((rdue_q.size() > 0) && (rdue_q[0] <= cyc)) begin
            cur_addr = raddr_q.pop_front();
            void'(rdue_q.pop_front());
            send_beat(cur_addr, 1'b0);
            second = 1'b1;
         end
         // gap bookkeeping follows what goes on the bus this cycle
         if (rsp.rd_valid) begin
            if (gap_open && (gap > max_rd_gap)) begin
               max_rd_gap = gap;
            end
            gap = 0;
            gap_open = 1'b1;
         end else begin
            gap = gap + 1;
         end
      end
      reads_pending = raddr_q.size() + int'(second);
   end

endmodule

/* dv/tb_ddr_test.sv */
`timescale 1ns/1ps
`include "ddr_test_defines.svh"

module tb_ddr_test;

   import ddr_test_pkg::*;

   localparam int MAX_ADDRS   = 12;
   localparam int TOTAL_ITERS = 8;
   localparam int LIMIT_NS    = (TOTAL_ITERS * MAX_ADDRS * 40 + 3000) * 20;

   logic                   clk;
   logic                   reset;
   logic                   req;
   logic                   we;
   logic [`REG_ADDR_W-1:0] addr;
   logic [31:0]            wdata;
   logic                   ack;
   logic [31:0]            rdata;
   logic                   calib_done;
   app_req_t               app_req;
   app_wdata_t             app_wdata;
   app_rsp_t               app_rsp;
   logic                   inject_en;
   logic [`DDR_ADDR_W-1:0] inject_addr;
   logic                   clear_counts;
   int                     wr_beats;
   int                     rd_beats;
   int                     bad_beats;
   int                     max_wr_stall;
   int                     max_rd_gap;
   int                     reads_pending;
   integer                 seed = 32'h75a3;
   int                     checks;
   int                     errors;

   ddr_test_top i_dut (
      .clk(clk), .reset(reset), .req(req), .we(we), .addr(addr), .wdata(wdata),
      .ack(ack), .rdata(rdata), .calib_done(calib_done), .app_req(app_req),
      .app_wdata(app_wdata), .app_rsp(app_rsp)
   );

   app_mem_model i_mem (
      .clk(clk), .reset(reset), .req(app_req), .wdata(app_wdata),
      .inject_en(inject_en), .inject_addr(inject_addr), .clear_counts(clear_counts),
      .rsp(app_rsp), .wr_beats(wr_beats), .rd_beats(rd_beats), .bad_beats(bad_beats),
      .max_wr_stall(max_wr_stall), .max_rd_gap(max_rd_gap),
      .reads_pending(reads_pending)
   );

   always #10 clk = ~clk;

   task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
      checks = checks + 1;
      if (got !== exp) begin
         errors = errors + 1;
         $display("FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      end
   endtask

   function automatic int rand_below(input int m);
      return int'($unsigned($random(seed)) % m);
   endfunction

   // taps 31, 21, 1, 0, shifted in at the bottom
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic wait_ack(input logic level);
      int n;
      n = 0;
      @(posedge clk);
      while ((ack !== level) && (n < 20)) begin
         n = n + 1;
         @(posedge clk);
      end
      if (ack !== level) begin
         errors = errors + 1;
         $display("host handshake stuck, ack never went to %0d at %0t ns", level, $time);
      end
   endtask

   task automatic reg_write(input logic [3:0] a, input logic [31:0] d);
      @(posedge clk);
      req   <= 1'b1;
      we    <= 1'b1;
      addr  <= a;
      wdata <= d;
      wait_ack(1'b1);
      req <= 1'b0;
      we  <= 1'b0;
      wait_ack(1'b0);
   endtask

   task automatic reg_read(input logic [3:0] a, output logic [31:0] d);
      @(posedge clk);
      req  <= 1'b1;
      we   <= 1'b0;
      addr <= a;
      wait_ack(1'b1);
      d = rdata;                   // valid while ack is high
      req <= 1'b0;
      wait_ack(1'b0);
   endtask

   task automatic wait_idle();
      logic [31:0] v;
      reg_read(`REG_STATUS, v);
      while (v[31:16] != 16'd0) begin
         reg_read(`REG_STATUS, v);
      end
      while (reads_pending != 0) begin
         @(posedge clk);
      end
      repeat (4) @(posedge clk);
   endtask

   // iteration 1 overwrites a prefix of the range, the rest still holds iteration 0
   task automatic check_memory(input int n, input int incr);
      logic [31:0] s0;
      logic [31:0] s1;
      logic [31:0] got;
      logic [31:0] a;
      logic        older;
      int          fresh;
      s0 = {16'd0, 16'hffff};
      s1 = {16'd1, 16'hfffe};
      older = 1'b0;
      fresh = 0;
      for (int i = 0; i < n; i++) begin
         a = i * incr;
         for (int b = 0; b < 2; b++) begin
            got = i_mem.stored(2 * longint'(a) + b);
            if (!older && (got !== (s1 ^ a))) begin
               older = 1'b1;
            end
            if (older) begin
               check($sformatf("stored beat %0d at %h", b, a), got, s0 ^ a);
            end
            s0 = lfsr_next(s0);
            s1 = lfsr_next(s1);
         end
         if (!older) begin
            fresh = fresh + 1;
         end
      end
      check("addresses rewritten by iteration 1", fresh > 0, 1'b1);
   endtask

   task automatic single_run(input logic inject);
      logic [31:0] v;
      int          n;
      int          incr;
      n    = 6 + rand_below(MAX_ADDRS - 5);
      incr = 1 + rand_below(8);
      reg_write(`REG_INCR, incr);
      reg_write(`REG_STOP, incr * (n - 1));
      @(posedge clk);
      inject_en    <= inject;
      inject_addr  <= rand_below(n) * incr;
      clear_counts <= 1'b1;
      @(posedge clk);
      clear_counts <= 1'b0;
      reg_write(`REG_CTRL, 32'd1);
      reg_read(`REG_STATUS, v);
      while (v[31:16] < 16'd1) begin
         reg_read(`REG_STATUS, v);
      end
      reg_write(`REG_CTRL, 32'd0);   // stop early in the second write pass
      wait_idle();
      check_memory(n, incr);
      reg_read(`REG_RD_BUSY, v);
      check("read busy", v, 2 * n);
      check("read beats on bus", rd_beats, 2 * n);
      reg_read(`REG_WR_BUSY, v);
      check("write busy", v, wr_beats);
      check("write busy covers range", v >= 2 * n, 1'b1);
      reg_read(`REG_RD_IDLE, v);
      check("read idle covers longest gap", v >= max_rd_gap, 1'b1);
      reg_read(`REG_WR_IDLE, v);
      check("write idle covers longest stall", v >= max_wr_stall, 1'b1);
      reg_read(`REG_MAX_STALL, v);
      check("read max stall", v[15:0] >= max_rd_gap, 1'b1);
      check("write max stall", v[31:16] >= max_wr_stall, 1'b1);
      reg_read(`REG_STATUS, v);
      check("pass after stop", v[0], 1'b0);
      if (inject) begin
         check("fail flag", v[1], 1'b1);
         check("error count", v[15:8], bad_beats);
         check("corrupted beats", bad_beats, 2);
         reg_read(`REG_ERR_ADDR, v);
         check("error address", v, inject_addr);
         reg_write(`REG_CTRL, 32'd2);
         reg_read(`REG_STATUS, v);
         check("fail after clear", v[1], 1'b0);
         check("errors after clear", v[15:8], 8'd0);
         reg_read(`REG_ERR_ADDR, v);
         check("error address after clear", v, 32'd0);
      end else begin
         check("fail flag clean", v[1], 1'b0);
      end
      inject_en <= 1'b0;
   endtask

   initial begin
      #(LIMIT_NS);
      $display("run did not finish in %0d ns, stopped by watchdog", LIMIT_NS);
      $display("tests failed");
      $finish;
   end

   initial begin
      logic [31:0] v;
      logic [31:0] x;
      clk          = 1'b0;
      reset        = 1'b1;
      req          = 1'b0;
      we           = 1'b0;
      addr         = '0;
      wdata        = '0;
      calib_done   = 1'b0;
      inject_en    = 1'b0;
      inject_addr  = '0;
      clear_counts = 1'b0;
      checks       = 0;
      errors       = 0;
      repeat (8) @(posedge clk);
      reset <= 1'b0;
      repeat (5) @(posedge clk);
      calib_done <= 1'b1;

      for (int i = 0; i < 4; i++) begin   // register readback
         x = rand_below(256);
         reg_write(`REG_INCR, x);
         reg_read(`REG_INCR, v);
         check("incr readback", v, x);
         x = $random(seed) & 32'h3fff_ffff;
         reg_write(`REG_STOP, x);
         reg_read(`REG_STOP, v);
         check("stop readback", v, x);
      end

      reg_write(`REG_INCR, 32'd4);   // clean run of three iterations
      reg_write(`REG_STOP, 32'd4 * (MAX_ADDRS - 1));
      reg_write(`REG_CTRL, 32'd1);
      reg_read(`REG_STATUS, v);
      while (v[31:16] < 16'd3) begin
         reg_read(`REG_STATUS, v);
      end
      check("pass during clean run", v[0], 1'b1);
      check("fail during clean run", v[1], 1'b0);
      reg_write(`REG_CTRL, 32'd0);
      wait_idle();
      reg_read(`REG_STATUS, v);
      check("iteration after stop", v[31:16], 16'd0);
      check("pass after stop", v[0], 1'b0);

      single_run(1'b0);
      single_run(1'b1);

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

/* sources.f */
+incdir+hw
hw/ddr_test_pkg.sv
hw/ddr_test_regs.sv
hw/pattern_lfsr.sv
hw/ddr_rw_sequencer.sv
hw/read_checker.sv
hw/ddr_traffic_stats.sv
hw/ddr_test_top.sv
dv/app_mem_model.sv
dv/tb_ddr_test.sv
